// File: build.f
+incdir+hw
hw/rv_pkg.sv
hw/alu.sv
hw/decode_stage.sv
hw/id_ex_reg.sv
hw/ex_stage.sv
hw/rv_slice_top.sv
testbench/tb_rv_slice.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module tb_rv_slice -o sim_rv_slice

# a fatal stop still leaves the output to be searched
out=$(./obj_dir/sim_rv_slice) || true
echo "$out"

if grep -q "Regression passed" <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_rv_slice.sv
// rv32i slice testbench

`timescale 1ns/10ps
`include "rv_settings.svh"

module tb_rv_slice;
    localparam int REG_INIT    = `RV_REG_COUNT - 1;
    localparam int NUM_INSTR   = 400;
    localparam int CYCLE_LIMIT = (REG_INIT + NUM_INSTR) * 2 + 20;

    typedef struct packed {
        logic              wen;
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t     data;
        rv_pkg::byte_en_t  we;
        rv_pkg::word_t     addr;
        rv_pkg::word_t     wdata;
        logic [31:0]       due;
        logic [15:0]       idx;
    } retire_t;

    logic              clk;
    logic              rst_n;
    rv_pkg::word_t     instr;
    logic              instr_valid;
    logic              retire_valid;
    logic              retire_wen;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_data;
    rv_pkg::byte_en_t  store_we;
    rv_pkg::word_t     store_addr;
    rv_pkg::word_t     store_data;

    logic [31:0]       lfsr_q = 32'hc92b912f;
    int unsigned       cycle = 0;
    rv_pkg::word_t     model_regs [`RV_REG_COUNT];
    rv_pkg::word_t     model_pc;
    retire_t           exp_q [$];

    rv_slice_top UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_i        (instr),
        .instr_valid_i  (instr_valid),
        .retire_valid_o (retire_valid),
        .retire_wen_o   (retire_wen),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data),
        .store_we_o     (store_we),
        .store_addr_o   (store_addr),
        .store_data_o   (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Error: %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // mostly x0..x3 so neighbours depend on each other
    function automatic rv_pkg::reg_addr_t pick_reg();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        if (sel < 3'd6) begin
            return rv_pkg::reg_addr_t'(rand_bits(2));
        end
        return rv_pkg::reg_addr_t'(rand_bits(5));
    endfunction

    function automatic rv_pkg::word_t gen_instr();
        logic [3:0]        kind;
        rv_pkg::reg_addr_t rd;
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        logic [2:0]        f3;
        logic [11:0]       imm12;
        logic [19:0]       imm20;
        logic              alt;
        rv_pkg::word_t     w;
        kind  = 4'(rand_bits(4));
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = 3'(rand_bits(3));
        imm12 = 12'(rand_bits(12));
        imm20 = 20'(rand_bits(20));
        alt   = 1'(rand_bits(1));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: begin
                w = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd,
                     7'b0110011};
            end
            4'd4, 4'd5, 4'd6, 4'd7: begin
                // shifts take a legal shamt encoding
                if (f3 == 3'd1) begin
                    imm12 = {7'b0, imm12[4:0]};
                end else if (f3 == 3'd5) begin
                    imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
                end
                w = {imm12, rs1, f3, rd, 7'b0010011};
            end
            4'd8:  w = {imm20, rd, 7'b0110111};
            4'd9:  w = {imm20, rd, 7'b0010111};
            4'd10: w = {imm20, rd, 7'b1101111};
            4'd11: w = {imm12, rs1, 3'b000, rd, 7'b1100111};
            4'd12, 4'd13: begin
                f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                w  = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
            end
            // load opcode is not supported here
            4'd14: w = {imm12, rs1, f3, rd, 7'b0000011};
            default: w = {imm12, rs1, 3'b000, 5'd0, 7'b0010011};
        endcase
        return w;
    endfunction

    function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // isa model steps one issued instruction at a time
    task automatic model_issue(input rv_pkg::word_t ins, input int idx);
        retire_t       e;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t imm_i;
        rv_pkg::word_t imm_s;
        rv_pkg::word_t imm_u;
        logic [2:0]    f3;
        logic          wr;
        e     = '0;
        wr    = 1'b0;
        f3    = ins[14:12];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_u = {ins[31:12], 12'b0};
        case (ins[6:0])
            7'b0110011: begin
                wr     = 1'b1;
                e.data = alu_ref(f3, ins[30], a, b);
            end
            7'b0010011: begin
                wr     = 1'b1;
                e.data = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
            end
            7'b0110111: begin
                wr     = 1'b1;
                e.data = imm_u;
            end
            7'b0010111: begin
                wr     = 1'b1;
                e.data = model_pc + imm_u;
            end
            7'b1101111, 7'b1100111: begin
                wr     = 1'b1;
                e.data = model_pc + 32'd4;
            end
            7'b0100011: begin
                e.addr = a + imm_s;
                case (f3)
                    3'd0: begin
                        e.we[e.addr[1:0]] = 1'b1;
                        e.wdata           = {4{b[7:0]}};
                    end
                    3'd1: begin
                        e.we    = e.addr[1] ? 4'b1100 : 4'b0011;
                        e.wdata = {2{b[15:0]}};
                    end
                    default: begin
                        e.we    = 4'b1111;
                        e.wdata = b;
                    end
                endcase
            end
            default: ;
        endcase
        e.wen = wr && (ins[11:7] != 5'd0);
        e.rd  = ins[11:7];
        if (e.wen) begin
            model_regs[ins[11:7]] = e.data;
        end
        // taken at the next edge and retired two edges from now
        e.due    = cycle + 32'd3;
        e.idx    = 16'(idx);
        model_pc = model_pc + 32'd4;
        exp_q.push_back(e);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            stop_with_failure("timeout: not all instructions retired in time");
        end
    end

    always @(negedge clk) begin : check_retire
        retire_t e;
        if (rst_n) begin
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("an instruction retired that was never issued");
                end
                e = exp_q.pop_front();
                compare_value($sformatf("instr %0d latency", e.idx), e.due, cycle);
                compare_value($sformatf("instr %0d wen", e.idx), 32'(e.wen), 32'(retire_wen));
                if (e.wen) begin
                    compare_value($sformatf("instr %0d rd", e.idx), 32'(e.rd), 32'(retire_rd));
                    compare_value($sformatf("instr %0d data", e.idx), e.data, retire_data);
                end
                compare_value($sformatf("instr %0d store_we", e.idx), 32'(e.we), 32'(store_we));
                if (e.we != 4'b0000) begin
                    compare_value($sformatf("instr %0d store_addr", e.idx), e.addr, store_addr);
                    compare_value($sformatf("instr %0d store_data", e.idx), e.wdata, store_data);
                end
            end else begin
                compare_value("idle store_we", 32'd0, 32'(store_we));
                if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                    stop_with_failure("an instruction did not retire two cycles after issue");
                end
            end
        end
    end

    initial begin : stimulus
        rv_pkg::word_t ins;
        int            n;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        model_pc    = `RV_RESET_PC;
        for (n = 0; n < `RV_REG_COUNT; n++) begin
            model_regs[n] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // quiet cycles before the first instruction
        repeat (4) @(posedge clk);
        for (n = 0; n < REG_INIT + NUM_INSTR; n++) begin
            if (n >= REG_INIT && rand_bits(2) == 32'd0) begin
                instr       <= rand_bits(32);
                instr_valid <= 1'b0;
                @(posedge clk);
            end
            // first fill every register through addi from x0
            if (n < REG_INIT) begin
                ins = {12'(rand_bits(12)), 5'd0, 3'b000, 5'(n + 1), 7'b0010011};
            end else begin
                ins = gen_instr();
            end
            instr       <= ins;
            instr_valid <= 1'b1;
            model_issue(ins, n);
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: hw/rv_slice_top.sv
// rv32i datapath slice top

`timescale 1ns/10ps

module rv_slice_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  rv_pkg::word_t       instr_i,
    input  logic                instr_valid_i,
    output logic                retire_valid_o,
    output logic                retire_wen_o,
    output rv_pkg::reg_addr_t   retire_rd_o,
    output rv_pkg::word_t       retire_data_o,
    output rv_pkg::byte_en_t    store_we_o,
    output rv_pkg::word_t       store_addr_o,
    output rv_pkg::word_t       store_data_o
);
    rv_pkg::id_ex_t id_ex_d;
    rv_pkg::id_ex_t id_ex_q;
    rv_pkg::ex_wb_t ex_wb_q;

    decode_stage u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .wb_i          (ex_wb_q),
        .id_ex_o       (id_ex_d)
    );

    id_ex_reg u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .id_ex_i (id_ex_d),
        .id_ex_o (id_ex_q)
    );

    ex_stage u_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .id_ex_i (id_ex_q),
        .ex_wb_o (ex_wb_q)
    );

    // retire port
    assign retire_valid_o = ex_wb_q.valid;
    assign retire_wen_o   = ex_wb_q.wb_en;
    assign retire_rd_o    = ex_wb_q.rd_addr;
    assign retire_data_o  = ex_wb_q.wb_data;
    assign store_we_o     = ex_wb_q.mem_we;
    assign store_addr_o   = ex_wb_q.mem_addr;
    assign store_data_o   = ex_wb_q.mem_wdata;

endmodule

// File: hw/ex_stage.sv
// execute stage and ex/wb register

`timescale 1ns/10ps

module ex_stage (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  rv_pkg::id_ex_t id_ex_i,
    output rv_pkg::ex_wb_t ex_wb_o
);
    rv_pkg::ex_wb_t    ex_wb_d;
    rv_pkg::ex_wb_t    ex_wb_q;
    logic              fwd1;
    logic              fwd2;
    rv_pkg::word_t     rs1_val;
    rv_pkg::word_t     rs2_val;
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;
    rv_pkg::word_t     alu_res;
    rv_pkg::alu_ctrl_t ctrl;
    rv_pkg::byte_en_t  we;
    rv_pkg::word_t     wdata;
    logic [1:0]        offset;

    // forward from the instruction one ahead
    assign fwd1 = id_ex_i.fwd_en && ex_wb_q.valid && ex_wb_q.wb_en
               && (ex_wb_q.rd_addr == id_ex_i.rs1_addr) && (id_ex_i.rs1_addr != '0);
    assign fwd2 = id_ex_i.fwd_en && ex_wb_q.valid && ex_wb_q.wb_en
               && (ex_wb_q.rd_addr == id_ex_i.rs2_addr) && (id_ex_i.rs2_addr != '0);

    assign rs1_val = fwd1 ? ex_wb_q.wb_data : id_ex_i.rs1_data;
    assign rs2_val = fwd2 ? ex_wb_q.wb_data : id_ex_i.rs2_data;
    assign op_a    = id_ex_i.src1_pc ? id_ex_i.pc : rs1_val;
    assign op_b    = id_ex_i.src2_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_OP_ADD:  ctrl = rv_pkg::ALU_ADD;
            rv_pkg::ALU_OP_PASS: ctrl = rv_pkg::ALU_PASS_B;
            default: begin
                case (id_ex_i.funct3)
                    3'b000: ctrl = (id_ex_i.alu_op == rv_pkg::ALU_OP_REG && id_ex_i.alt_bit)
                                   ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: ctrl = rv_pkg::ALU_SLL;
                    3'b010: ctrl = rv_pkg::ALU_SLT;
                    3'b011: ctrl = rv_pkg::ALU_SLTU;
                    3'b100: ctrl = rv_pkg::ALU_XOR;
                    3'b101: ctrl = id_ex_i.alt_bit ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: ctrl = rv_pkg::ALU_OR;
                    default: ctrl = rv_pkg::ALU_AND;
                endcase
            end
        endcase
    end

    alu u_alu (
        .a_i      (op_a),
        .b_i      (op_b),
        .ctrl_i   (ctrl),
        .result_o (alu_res)
    );

    // store lane alignment
    assign offset = alu_res[1:0];

    always_comb begin
        case (id_ex_i.funct3[1:0])
            2'b00: begin
                we    = 4'b0001 << offset;
                wdata = {4{rs2_val[7:0]}};
            end
            2'b01: begin
                we    = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rs2_val[15:0]}};
            end
            default: begin
                we    = 4'b1111;
                wdata = rs2_val;
            end
        endcase
    end

    always_comb begin
        ex_wb_d           = '0;
        ex_wb_d.valid     = id_ex_i.valid;
        ex_wb_d.rd_addr   = id_ex_i.rd_addr;
        ex_wb_d.wb_en     = id_ex_i.valid && id_ex_i.wb_en;
        ex_wb_d.wb_data   = id_ex_i.wb_link ? id_ex_i.pc_plus : alu_res;
        ex_wb_d.store     = id_ex_i.valid && id_ex_i.store;
        ex_wb_d.mem_we    = (id_ex_i.valid && id_ex_i.store) ? we : 4'b0000;
        ex_wb_d.mem_addr  = alu_res;
        ex_wb_d.mem_wdata = wdata;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_wb_q.valid  <= 1'b0;
            ex_wb_q.wb_en  <= 1'b0;
            ex_wb_q.store  <= 1'b0;
            ex_wb_q.mem_we <= 4'b0000;
        end else begin
            ex_wb_q.valid  <= ex_wb_d.valid;
            ex_wb_q.wb_en  <= ex_wb_d.wb_en;
            ex_wb_q.store  <= ex_wb_d.store;
            ex_wb_q.mem_we <= ex_wb_d.mem_we;
        end
        ex_wb_q.rd_addr   <= ex_wb_d.rd_addr;
        ex_wb_q.wb_data   <= ex_wb_d.wb_data;
        ex_wb_q.mem_addr  <= ex_wb_d.mem_addr;
        ex_wb_q.mem_wdata <= ex_wb_d.mem_wdata;
    end

    assign ex_wb_o = ex_wb_q;

    // lanes only for a valid store that writes no register
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ex_wb_q.mem_we != '0) |-> (ex_wb_q.valid && ex_wb_q.store && !ex_wb_q.wb_en));

endmodule

// File: hw/id_ex_reg.sv
// id/ex pipeline register

`timescale 1ns/10ps

module id_ex_reg (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  rv_pkg::id_ex_t id_ex_i,
    output rv_pkg::id_ex_t id_ex_o
);
    logic           valid_q;
    rv_pkg::id_ex_t payload_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= id_ex_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        payload_q <= id_ex_i;
    end

    always_comb begin
        id_ex_o       = payload_q;
        id_ex_o.valid = valid_q;
    end

    // no live instruction right out of reset
    assert property (@(posedge clk_i)
        !rst_n_i |=> !id_ex_o.valid);

endmodule

// File: hw/decode_stage.sv
// decode stage with register file

`timescale 1ns/10ps
`include "rv_settings.svh"

module decode_stage (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  rv_pkg::word_t  instr_i,
    input  logic           instr_valid_i,
    input  rv_pkg::ex_wb_t wb_i,
    output rv_pkg::id_ex_t id_ex_o
);
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    rv_pkg::word_t     pc_q;
    rv_pkg::word_t     regs [`RV_REG_COUNT];
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_s;
    rv_pkg::word_t     imm_u;
    rv_pkg::word_t     imm_j;
    logic              rf_we;
    rv_pkg::id_ex_t    d;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // pc counts accepted instructions only
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (instr_valid_i) begin
            pc_q <= pc_q + rv_pkg::word_t'(4);
        end
    end

    assign rf_we = wb_i.valid && wb_i.wb_en && (wb_i.rd_addr != '0);

    always_ff @(posedge clk_i) begin
        if (rf_we) begin
            regs[wb_i.rd_addr] <= wb_i.wb_data;
        end
    end

    // x0 reads zero and a same-cycle write is bypassed
    function automatic rv_pkg::word_t rf_read(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (rf_we && (wb_i.rd_addr == addr)) begin
            return wb_i.wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        d          = '0;
        d.valid    = instr_valid_i;
        d.pc       = pc_q;
        d.pc_plus  = pc_q + rv_pkg::word_t'(4);
        d.rs1_addr = rs1;
        d.rs2_addr = rs2;
        d.rd_addr  = rd;
        d.rs1_data = rf_read(rs1);
        d.rs2_data = rf_read(rs2);
        d.funct3   = instr_i[14:12];
        d.alt_bit  = instr_i[30];
        case (instr_i[6:0])
            OPC_OP: begin
                d.alu_op = rv_pkg::ALU_OP_REG;
                d.fwd_en = 1'b1;
                d.wb_en  = 1'b1;
            end
            OPC_OP_IMM: begin
                d.alu_op   = rv_pkg::ALU_OP_IMM;
                d.imm      = imm_i;
                d.src2_imm = 1'b1;
                d.fwd_en   = 1'b1;
                d.wb_en    = 1'b1;
            end
            OPC_LUI: begin
                d.alu_op   = rv_pkg::ALU_OP_PASS;
                d.imm      = imm_u;
                d.src2_imm = 1'b1;
                d.wb_en    = 1'b1;
            end
            OPC_AUIPC: begin
                d.alu_op   = rv_pkg::ALU_OP_ADD;
                d.imm      = imm_u;
                d.src1_pc  = 1'b1;
                d.src2_imm = 1'b1;
                d.wb_en    = 1'b1;
            end
            OPC_JAL: begin
                d.alu_op   = rv_pkg::ALU_OP_ADD;
                d.imm      = imm_j;
                d.src1_pc  = 1'b1;
                d.src2_imm = 1'b1;
                d.wb_en    = 1'b1;
                d.wb_link  = 1'b1;
            end
            OPC_JALR: begin
                d.alu_op   = rv_pkg::ALU_OP_ADD;
                d.imm      = imm_i;
                d.src2_imm = 1'b1;
                d.fwd_en   = 1'b1;
                d.wb_en    = 1'b1;
                d.wb_link  = 1'b1;
            end
            OPC_STORE: begin
                d.alu_op   = rv_pkg::ALU_OP_ADD;
                d.imm      = imm_s;
                d.src2_imm = 1'b1;
                d.fwd_en   = 1'b1;
                // only sb, sh, sw
                d.store    = (instr_i[14:12] <= 3'd2);
            end
            default: begin
                // unsupported opcode retires as a no-op
                d.alu_op = rv_pkg::ALU_OP_ADD;
            end
        endcase
        if (rd == '0 || d.store) begin
            d.wb_en = 1'b0;
        end
    end

    assign id_ex_o = d;

    // execute must never hand back a write to x0
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_i.valid && wb_i.wb_en) |-> (wb_i.rd_addr != '0));

endmodule

// File: hw/alu.sv
// rv32i alu

`timescale 1ns/10ps

module alu (
    input  rv_pkg::word_t     a_i,
    input  rv_pkg::word_t     b_i,
    input  rv_pkg::alu_ctrl_t ctrl_i,
    output rv_pkg::word_t     result_o
);
    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b_i[4:0];

    always_comb begin
        case (ctrl_i)
            rv_pkg::ALU_ADD: begin
                result_o = a_i + b_i;
            end
            rv_pkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            rv_pkg::ALU_SLL: begin
                result_o = a_i << shamt;
            end
            rv_pkg::ALU_SLT: begin
                result_o = ($signed(a_i) < $signed(b_i)) ? rv_pkg::word_t'(1) : '0;
            end
            rv_pkg::ALU_SLTU: begin
                result_o = (a_i < b_i) ? rv_pkg::word_t'(1) : '0;
            end
            rv_pkg::ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            rv_pkg::ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                result_o = rv_pkg::word_t'($signed(a_i) >>> shamt);
            end
            rv_pkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            rv_pkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            rv_pkg::ALU_PASS_B: begin
                // lui
                result_o = b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: hw/rv_pkg.sv
// rv32i slice types

`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    typedef logic [3:0]            byte_en_t;
    typedef logic [3:0]            alu_ctrl_t;
    typedef logic [1:0]            alu_op_t;

    // alu operations
    localparam alu_ctrl_t ALU_ADD    = 4'd0;
    localparam alu_ctrl_t ALU_SUB    = 4'd1;
    localparam alu_ctrl_t ALU_SLL    = 4'd2;
    localparam alu_ctrl_t ALU_SLT    = 4'd3;
    localparam alu_ctrl_t ALU_SLTU   = 4'd4;
    localparam alu_ctrl_t ALU_XOR    = 4'd5;
    localparam alu_ctrl_t ALU_SRL    = 4'd6;
    localparam alu_ctrl_t ALU_SRA    = 4'd7;
    localparam alu_ctrl_t ALU_OR     = 4'd8;
    localparam alu_ctrl_t ALU_AND    = 4'd9;
    localparam alu_ctrl_t ALU_PASS_B = 4'd10;

    // decoder operation classes
    localparam alu_op_t ALU_OP_ADD  = 2'd0;
    localparam alu_op_t ALU_OP_REG  = 2'd1;
    localparam alu_op_t ALU_OP_IMM  = 2'd2;
    localparam alu_op_t ALU_OP_PASS = 2'd3;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     pc_plus;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic [2:0] funct3;
        logic      alt_bit;
        alu_op_t   alu_op;
        logic      src1_pc;
        logic      src2_imm;
        logic      fwd_en;
        logic      store;
        logic      wb_en;
        logic      wb_link;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd_addr;
        logic      wb_en;
        word_t     wb_data;
        logic      store;
        byte_en_t  mem_we;
        word_t     mem_addr;
        word_t     mem_wdata;
    } ex_wb_t;

endpackage

// File: hw/rv_settings.svh
// rv32i slice settings

`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data word width
`define RV_XLEN 32

// register index width
`define RV_REG_AW 5

// number of integer registers
`define RV_REG_COUNT 32

// pc value after reset
`define RV_RESET_PC 32'h0000_0000

`endif
